// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --assert --timescale 1ns/100ps -j 0
TOP      = tb_alarm_clock
FILELIST = alarm_clock_top.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "simulation failed"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== alarm_clock_top.f ====
common/clock_pkg.sv
common/ctrl_if.sv
panel/key_debounce.sv
panel/panel_ctrl.sv
timekeep/time_core.sv
display/seg_scan.sv
logic/alarm_clock_top.sv
verif/tb_alarm_clock.sv

// ==== common/clock_pkg.sv ====
package clock_pkg;

	// ----------------------------------------
	// time fields
	// ----------------------------------------
	localparam int TIME_W = 6;	// wide enough for 0..59

	localparam logic [TIME_W-1:0] MAX_SEC = 6'd59;
	localparam logic [TIME_W-1:0] MAX_MIN = 6'd59;
	localparam logic [TIME_W-1:0] MAX_HR  = 6'd23;

	// ----------------------------------------
	// mode and position codes
	// ----------------------------------------
	localparam int MODE_W = 2;
	localparam int POS_W  = 2;

	localparam logic [MODE_W-1:0] MODE_CLOCK = 2'd0;	// normal counting
	localparam logic [MODE_W-1:0] MODE_SETUP = 2'd1;	// time set, counting stopped
	localparam logic [MODE_W-1:0] MODE_ALARM = 2'd2;	// alarm set, time still runs

	localparam logic [POS_W-1:0] POS_SEC = 2'd0;
	localparam logic [POS_W-1:0] POS_MIN = 2'd1;
	localparam logic [POS_W-1:0] POS_HR  = 2'd2;

	// ----------------------------------------
	// display
	// ----------------------------------------
	localparam int NUM_DIGITS = 6;
	localparam int SEG_W      = 7;	// {a,b,c,d,e,f,g}

	// lit segment is 1
	localparam logic [SEG_W-1:0] SEG_FONT [0:9] = '{
		7'b111_1110,	// 0
		7'b011_0000,	// 1
		7'b110_1101,	// 2
		7'b111_1001,	// 3
		7'b011_0011,	// 4
		7'b101_1011,	// 5
		7'b101_1111,	// 6
		7'b111_0000,	// 7
		7'b111_1111,	// 8
		7'b111_0011	// 9
	};

endpackage

// ==== common/ctrl_if.sv ====
interface ctrl_if;

	logic [clock_pkg::MODE_W-1:0]	mode;	// current operating mode
	logic [clock_pkg::POS_W-1:0]	pos;	// field picked for increment
	logic				inc;	// one-cycle increment command
	logic				alarm_en;

	// button panel side
	modport panel (
		output	mode,
		output	pos,
		output	inc,
		output	alarm_en
	);

	// timekeeping side
	modport core (
		input	mode,
		input	pos,
		input	inc,
		input	alarm_en
	);

endinterface

// ==== display/seg_scan.sv ====
module seg_scan #(
	parameter int SCAN_DIV = 5000
) (
	input  logic					clk,
	input  logic					rst_n,
	input  logic [clock_pkg::TIME_W-1:0]		i_hr,
	input  logic [clock_pkg::TIME_W-1:0]		i_min,
	input  logic [clock_pkg::TIME_W-1:0]		i_sec,
	output logic [clock_pkg::SEG_W-1:0]		o_seg,
	output logic [clock_pkg::NUM_DIGITS-1:0]	o_seg_enb	// active low
);

	localparam int DIGITS = clock_pkg::NUM_DIGITS;
	localparam int SLOT_W = $clog2(DIGITS);
	localparam int DIV_W  = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

	logic [DIV_W-1:0]	div_cnt;
	logic			step;
	logic [SLOT_W-1:0]	slot;
	logic [3:0]		digit [DIGITS];

	function automatic logic [3:0] tens(input logic [clock_pkg::TIME_W-1:0] val);
		return 4'(val / 10);
	endfunction

	function automatic logic [3:0] ones(input logic [clock_pkg::TIME_W-1:0] val);
		return 4'(val % 10);
	endfunction

	// ----------------------------------------
	// scan timing
	// ----------------------------------------
	assign step = (div_cnt == DIV_W'(SCAN_DIV - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			slot    <= '0;
		end else if (step) begin
			div_cnt <= '0;
			slot    <= (slot == SLOT_W'(DIGITS - 1)) ? '0 : slot + 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// ----------------------------------------
	// digit split, slot 0 is rightmost
	// ----------------------------------------
	always_comb begin
		digit[0] = ones(i_sec);
		digit[1] = tens(i_sec);
		digit[2] = ones(i_min);
		digit[3] = tens(i_min);
		digit[4] = ones(i_hr);
		digit[5] = tens(i_hr);
	end

	// enable and pattern registered together so they line up
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_seg_enb <= ~DIGITS'(1);
		end else begin
			o_seg_enb <= ~(DIGITS'(1) << slot);
		end
	end

	always_ff @(posedge clk) begin
		o_seg <= clock_pkg::SEG_FONT[digit[slot]];
	end

	a_one_enable: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot(~o_seg_enb)
	);

endmodule

// ==== logic/alarm_clock_top.sv ====
module alarm_clock_top #(
	parameter int CLK_PER_SEC = 50000000,
	parameter int SCAN_DIV    = 5000,
	parameter int SAMPLE_DIV  = 500000
) (
	input  logic					clk,
	input  logic					rst_n,
	input  logic					i_btn_mode,
	input  logic					i_btn_pos,
	input  logic					i_btn_inc,
	input  logic					i_btn_alarm,
	output logic [clock_pkg::SEG_W-1:0]		o_seg,
	output logic [clock_pkg::NUM_DIGITS-1:0]	o_seg_enb,
	output logic					o_alarm
);

	// panel to core
	ctrl_if u_ctrl ();

	// core to display
	logic [clock_pkg::TIME_W-1:0]	disp_hr;
	logic [clock_pkg::TIME_W-1:0]	disp_min;
	logic [clock_pkg::TIME_W-1:0]	disp_sec;

	// ----------------------------------------
	// button panel
	// ----------------------------------------
	panel_ctrl #(
		.SAMPLE_DIV	(SAMPLE_DIV)
	) u_panel_ctrl (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_btn_mode	(i_btn_mode),
		.i_btn_pos	(i_btn_pos),
		.i_btn_inc	(i_btn_inc),
		.i_btn_alarm	(i_btn_alarm),
		.o_ctrl		(u_ctrl.panel)
	);

	// ----------------------------------------
	// timekeeping core
	// ----------------------------------------
	time_core #(
		.CLK_PER_SEC	(CLK_PER_SEC)
	) u_time_core (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_ctrl		(u_ctrl.core),
		.o_disp_hr	(disp_hr),
		.o_disp_min	(disp_min),
		.o_disp_sec	(disp_sec),
		.o_alarm	(o_alarm)
	);

	// ----------------------------------------
	// display scanner
	// ----------------------------------------
	seg_scan #(
		.SCAN_DIV	(SCAN_DIV)
	) u_seg_scan (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_hr		(disp_hr),
		.i_min		(disp_min),
		.i_sec		(disp_sec),
		.o_seg		(o_seg),
		.o_seg_enb	(o_seg_enb)
	);

endmodule

// ==== panel/key_debounce.sv ====
module key_debounce #(
	parameter int SAMPLE_DIV = 500000
) (
	input  logic	clk,
	input  logic	rst_n,
	input  logic	i_key,		// high while pressed
	output logic	o_press
);

	localparam int CNT_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;

	logic [1:0]		sync;		// metastability guard
	logic [CNT_W-1:0]	div_cnt;
	logic			sample_en;
	logic [1:0]		hist;		// [1] older, [0] newer sample
	logic			fresh;		// hist updated last cycle

	assign sample_en = (div_cnt == CNT_W'(SAMPLE_DIV - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync    <= 2'b00;
			div_cnt <= '0;
			hist    <= 2'b00;
			fresh   <= 1'b0;
		end else begin
			sync  <= {sync[0], i_key};
			fresh <= sample_en;
			if (sample_en) begin
				div_cnt <= '0;
				hist    <= {hist[0], sync[1]};
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// released then pressed, seen once per sample
	assign o_press = fresh & (hist == 2'b01);

endmodule

// ==== panel/panel_ctrl.sv ====
module panel_ctrl #(
	parameter int SAMPLE_DIV = 500000
) (
	input  logic	clk,
	input  logic	rst_n,
	input  logic	i_btn_mode,
	input  logic	i_btn_pos,
	input  logic	i_btn_inc,
	input  logic	i_btn_alarm,
	ctrl_if.panel	o_ctrl
);

	logic [3:0]	btn;
	logic [3:0]	press;		// one pulse per clean press

	logic [clock_pkg::MODE_W-1:0]	mode;
	logic [clock_pkg::POS_W-1:0]	pos;
	logic				alarm_en;
	logic				inc_q;

	assign btn = {i_btn_alarm, i_btn_inc, i_btn_pos, i_btn_mode};

	// ----------------------------------------
	// button conditioning
	// ----------------------------------------
	for (genvar i = 0; i < 4; i++) begin : g_key
		key_debounce #(
			.SAMPLE_DIV	(SAMPLE_DIV)
		) u_key (
			.clk		(clk),
			.rst_n		(rst_n),
			.i_key		(btn[i]),
			.o_press	(press[i])
		);
	end

	// ----------------------------------------
	// mode, position, alarm enable
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode     <= clock_pkg::MODE_CLOCK;
			pos      <= clock_pkg::POS_SEC;
			alarm_en <= 1'b0;
			inc_q    <= 1'b0;
		end else begin
			if (press[0]) begin
				case (mode)
					clock_pkg::MODE_CLOCK:	mode <= clock_pkg::MODE_SETUP;
					clock_pkg::MODE_SETUP:	mode <= clock_pkg::MODE_ALARM;
					default:		mode <= clock_pkg::MODE_CLOCK;
				endcase
			end
			if (press[1]) begin
				case (pos)
					clock_pkg::POS_SEC:	pos <= clock_pkg::POS_MIN;
					clock_pkg::POS_MIN:	pos <= clock_pkg::POS_HR;
					default:		pos <= clock_pkg::POS_SEC;
				endcase
			end
			if (press[3]) begin
				alarm_en <= ~alarm_en;
			end
			// increment has no meaning while just counting
			inc_q <= press[2] & (mode != clock_pkg::MODE_CLOCK);
		end
	end

	assign o_ctrl.mode     = mode;
	assign o_ctrl.pos      = pos;
	assign o_ctrl.inc      = inc_q;
	assign o_ctrl.alarm_en = alarm_en;

	a_mode_legal: assert property (
		@(posedge clk) disable iff (!rst_n)
		mode != 2'd3
	);

endmodule

// ==== timekeep/time_core.sv ====
module time_core #(
	parameter int CLK_PER_SEC = 50000000
) (
	input  logic				clk,
	input  logic				rst_n,
	ctrl_if.core				i_ctrl,
	output logic [clock_pkg::TIME_W-1:0]	o_disp_hr,
	output logic [clock_pkg::TIME_W-1:0]	o_disp_min,
	output logic [clock_pkg::TIME_W-1:0]	o_disp_sec,
	output logic				o_alarm
);

	localparam int TICK_W = (CLK_PER_SEC > 1) ? $clog2(CLK_PER_SEC) : 1;

	logic [TICK_W-1:0]		tick_cnt;
	logic				run;
	logic				tick;		// one cycle per second
	logic				set_inc;
	logic				al_inc;
	logic				match;

	logic [clock_pkg::TIME_W-1:0]	tm_sec, tm_min, tm_hr;
	logic [clock_pkg::TIME_W-1:0]	al_sec, al_min, al_hr;

	function automatic logic [clock_pkg::TIME_W-1:0] inc_wrap(
		input logic [clock_pkg::TIME_W-1:0] val,
		input logic [clock_pkg::TIME_W-1:0] lim
	);
		return (val >= lim) ? '0 : val + 1'b1;
	endfunction

	// ----------------------------------------
	// second tick
	// ----------------------------------------
	assign run  = (i_ctrl.mode != clock_pkg::MODE_SETUP);	// setup freezes time
	assign tick = run && (tick_cnt == TICK_W'(CLK_PER_SEC - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_cnt <= '0;
		end else if (tick) begin
			tick_cnt <= '0;
		end else if (run) begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	assign set_inc = i_ctrl.inc && (i_ctrl.mode == clock_pkg::MODE_SETUP);
	assign al_inc  = i_ctrl.inc && (i_ctrl.mode == clock_pkg::MODE_ALARM);

	// ----------------------------------------
	// current time
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tm_sec <= '0;
			tm_min <= '0;
			tm_hr  <= '0;
		end else if (tick) begin
			tm_sec <= inc_wrap(tm_sec, clock_pkg::MAX_SEC);
			if (tm_sec == clock_pkg::MAX_SEC) begin	// carry chain
				tm_min <= inc_wrap(tm_min, clock_pkg::MAX_MIN);
				if (tm_min == clock_pkg::MAX_MIN) begin
					tm_hr <= inc_wrap(tm_hr, clock_pkg::MAX_HR);
				end
			end
		end else if (set_inc) begin
			case (i_ctrl.pos)
				clock_pkg::POS_SEC:	tm_sec <= inc_wrap(tm_sec, clock_pkg::MAX_SEC);
				clock_pkg::POS_MIN:	tm_min <= inc_wrap(tm_min, clock_pkg::MAX_MIN);
				clock_pkg::POS_HR:	tm_hr  <= inc_wrap(tm_hr, clock_pkg::MAX_HR);
				default:		;
			endcase
		end
	end

	// alarm time set field by field without carry
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			al_sec <= '0;
			al_min <= '0;
			al_hr  <= '0;
		end else if (al_inc) begin
			case (i_ctrl.pos)
				clock_pkg::POS_SEC:	al_sec <= inc_wrap(al_sec, clock_pkg::MAX_SEC);
				clock_pkg::POS_MIN:	al_min <= inc_wrap(al_min, clock_pkg::MAX_MIN);
				clock_pkg::POS_HR:	al_hr  <= inc_wrap(al_hr, clock_pkg::MAX_HR);
				default:		;
			endcase
		end
	end

	// ----------------------------------------
	// alarm flag and display select
	// ----------------------------------------
	assign match = (tm_sec == al_sec) && (tm_min == al_min) && (tm_hr == al_hr);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= i_ctrl.alarm_en & (match | o_alarm);	// sticky until disabled
		end
	end

	assign o_disp_sec = (i_ctrl.mode == clock_pkg::MODE_ALARM) ? al_sec : tm_sec;
	assign o_disp_min = (i_ctrl.mode == clock_pkg::MODE_ALARM) ? al_min : tm_min;
	assign o_disp_hr  = (i_ctrl.mode == clock_pkg::MODE_ALARM) ? al_hr  : tm_hr;

	a_fields_in_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		(tm_sec <= clock_pkg::MAX_SEC) && (tm_min <= clock_pkg::MAX_MIN) &&
		(tm_hr <= clock_pkg::MAX_HR) && (al_sec <= clock_pkg::MAX_SEC) &&
		(al_min <= clock_pkg::MAX_MIN) && (al_hr <= clock_pkg::MAX_HR)
	);

endmodule

// ==== verif/tb_alarm_clock.sv ====
module tb_alarm_clock;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PER_SEC = 400;
	localparam int SCAN_DIV    = 2;
	localparam int SAMPLE_DIV  = 2;
	localparam int CLK_NS      = 4;
	localparam int HOLD_CYC    = 8;	// held, then released, this long
	localparam int MAX_STEPS   = 32;
	localparam int AL_SEC      = 15;	// alarm seconds, time starts near 00:00:05
	localparam int RUN1_CYC    = 20 * CLK_PER_SEC;
	localparam int RUN2_CYC    = 15 * CLK_PER_SEC;
	localparam int AL_WAIT     = (AL_SEC - 5 + 2) * CLK_PER_SEC;

	localparam int BTN_NONE  = 0;
	localparam int BTN_MODE  = 1;
	localparam int BTN_POS   = 2;
	localparam int BTN_INC   = 3;
	localparam int BTN_ALARM = 4;

	logic		clk;
	logic		rst_n;
	logic		btn_mode;
	logic		btn_pos;
	logic		btn_inc;
	logic		btn_alarm;
	logic [6:0]	seg;
	logic [5:0]	seg_enb;
	logic		alarm;

	// step table, each step waits, presses, then reads the display
	int	st_btn [MAX_STEPS];
	int	st_count [MAX_STEPS];
	int	st_wait [MAX_STEPS];
	int	st_hr [MAX_STEPS];
	int	st_min [MAX_STEPS];
	int	st_sec [MAX_STEPS];
	int	st_tol [MAX_STEPS];	// seconds
	logic	st_alarm [MAX_STEPS];
	int	n_steps;
	bit	table_ready;

	int	errors;
	int	steps_ok;
	int	got_digit [6];		// slot 0 is seconds ones

	alarm_clock_top #(
		.CLK_PER_SEC	(CLK_PER_SEC),
		.SCAN_DIV	(SCAN_DIV),
		.SAMPLE_DIV	(SAMPLE_DIV)
	) uut (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_btn_mode	(btn_mode),
		.i_btn_pos	(btn_pos),
		.i_btn_inc	(btn_inc),
		.i_btn_alarm	(btn_alarm),
		.o_seg		(seg),
		.o_seg_enb	(seg_enb),
		.o_alarm	(alarm)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// ----------------------------------------
	// segment font and display capture
	// ----------------------------------------
	function automatic logic [6:0] font_of(input int d);	// a..g, lit is 1
		case (d)
			0:		return 7'b111_1110;
			1:		return 7'b011_0000;
			2:		return 7'b110_1101;
			3:		return 7'b111_1001;
			4:		return 7'b011_0011;
			5:		return 7'b101_1011;
			6:		return 7'b101_1111;
			7:		return 7'b111_0000;
			8:		return 7'b111_1111;
			9:		return 7'b111_0011;
			default:	return 7'b000_0000;
		endcase
	endfunction

	function automatic int decode_seg(input logic [6:0] pat);
		int d;
		int found;
		found = -1;
		for (d = 0; d < 10; d++) begin
			if (font_of(d) == pat) found = d;
		end
		return found;
	endfunction

	// follows one full scan, slot by slot in order
	task automatic capture_display(output bit ok);
		int slot;
		int cyc;
		int limit;
		bit seen;
		ok = 1'b1;
		for (slot = 0; slot < 6; slot++) begin
			limit = (slot == 0) ? 6 * SCAN_DIV + 2 : 2 * SCAN_DIV;
			seen = 1'b0;
			cyc = 0;
			while (!seen && cyc < limit) begin
				@(negedge clk);
				cyc++;
				if ($countones(~seg_enb) != 1) begin
					$display("FAILED t=%0t o_seg_enb exp one bit low got %b", $time, seg_enb);
					ok = 1'b0;
				end
				if (seg_enb == 6'(~(6'b1 << slot))) begin
					seen = 1'b1;
					got_digit[slot] = decode_seg(seg);
				end
			end
			if (!seen) begin
				$display("digit slot %0d was not enabled in turn at %0t", slot, $time);
				ok = 1'b0;
			end else if (got_digit[slot] < 0) begin
				$display("slot %0d shows no digit, pattern %b at %0t", slot, seg, $time);
				ok = 1'b0;
			end
		end
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	task automatic add_step(input int btn, input int count, input int wait_cyc,
		input int hr, input int mn, input int sc, input int tol, input logic al);
		st_btn[n_steps] = btn;
		st_count[n_steps] = count;
		st_wait[n_steps] = wait_cyc;
		st_hr[n_steps] = hr;
		st_min[n_steps] = mn;
		st_sec[n_steps] = sc;
		st_tol[n_steps] = tol;
		st_alarm[n_steps] = al;
		n_steps++;
	endtask

	task automatic set_button(input int btn, input logic val);
		case (btn)
			BTN_MODE:	btn_mode = val;
			BTN_POS:	btn_pos = val;
			BTN_INC:	btn_inc = val;
			BTN_ALARM:	btn_alarm = val;
			default:	;
		endcase
	endtask

	task automatic press_button(input int btn);
		@(posedge clk);
		#1;
		set_button(btn, 1'b1);
		repeat (HOLD_CYC) @(posedge clk);
		#1;
		set_button(btn, 1'b0);
		repeat (HOLD_CYC) @(posedge clk);
	endtask

	task automatic run_step(input int i);
		int k;
		bit cap_ok;
		int step_err;
		int exp_s;
		int got_s;
		int diff;
		step_err = 0;
		repeat (st_wait[i]) @(posedge clk);
		for (k = 0; k < st_count[i]; k++) begin
			press_button(st_btn[i]);
		end
		capture_display(cap_ok);
		if (!cap_ok) step_err++;
		exp_s = st_hr[i] * 3600 + st_min[i] * 60 + st_sec[i];
		got_s = (got_digit[5] * 10 + got_digit[4]) * 3600 +
			(got_digit[3] * 10 + got_digit[2]) * 60 + got_digit[1] * 10 + got_digit[0];
		diff = (got_s - exp_s + 86400) % 86400;
		if (diff > 43200) diff = 86400 - diff;	// distance around midnight
		if (diff > st_tol[i]) begin
			$display("FAILED t=%0t o_seg time exp %02d:%02d:%02d got %0d%0d:%0d%0d:%0d%0d",
				$time, st_hr[i], st_min[i], st_sec[i], got_digit[5], got_digit[4],
				got_digit[3], got_digit[2], got_digit[1], got_digit[0]);
			step_err++;
		end
		if (alarm !== st_alarm[i]) begin
			$display("FAILED t=%0t o_alarm exp %b got %b", $time, st_alarm[i], alarm);
			step_err++;
		end
		$display("step %0d: %s", i + 1, (step_err == 0) ? "ok" : "wrong");
		errors += step_err;
		if (step_err == 0) steps_ok++;
	endtask

	initial begin
		int n_sec;
		int s;
		int i;
		rst_n = 1'b0;
		btn_mode = 1'b0;
		btn_pos = 1'b0;
		btn_inc = 1'b0;
		btn_alarm = 1'b0;
		n_steps = 0;
		errors = 0;
		steps_ok = 0;
		void'($urandom(32'h9552));
		n_sec = 1 + ($urandom % 70);
		s = n_sec % 60;

		add_step(BTN_NONE,  0,                      0,        0,  0,  0,      0, 1'b0);
		add_step(BTN_MODE,  1,                      0,        0,  0,  0,      0, 1'b0);
		add_step(BTN_INC,   n_sec,                  0,        0,  0,  s,      0, 1'b0);
		add_step(BTN_POS,   1,                      0,        0,  0,  s,      0, 1'b0);
		add_step(BTN_INC,   59,                     0,        0,  59, s,      0, 1'b0);
		add_step(BTN_POS,   1,                      0,        0,  59, s,      0, 1'b0);
		add_step(BTN_INC,   25,                     0,        1,  59, s,      0, 1'b0);
		add_step(BTN_INC,   23,                     0,        0,  59, s,      0, 1'b0);
		add_step(BTN_POS,   1,                      0,        0,  59, s,      0, 1'b0);
		add_step(BTN_INC,   (50 - s + 60) % 60,     0,        0,  59, 50,     0, 1'b0);
		add_step(BTN_MODE,  2,                      0,        0,  59, 50,     2, 1'b0);
		add_step(BTN_MODE,  1,                      RUN1_CYC, 1,  0,  10,     2, 1'b0);
		add_step(BTN_POS,   1,                      0,        1,  0,  10,     2, 1'b0);
		add_step(BTN_INC,   59,                     0,        1,  59, 10,     2, 1'b0);
		add_step(BTN_POS,   1,                      0,        1,  59, 10,     2, 1'b0);
		add_step(BTN_INC,   22,                     0,        23, 59, 10,     2, 1'b0);
		add_step(BTN_POS,   1,                      0,        23, 59, 10,     2, 1'b0);
		add_step(BTN_INC,   40,                     0,        23, 59, 50,     2, 1'b0);
		add_step(BTN_MODE,  2,                      0,        23, 59, 50,     2, 1'b0);
		add_step(BTN_MODE,  1,                      RUN2_CYC, 0,  0,  5,      2, 1'b0);
		add_step(BTN_MODE,  1,                      0,        0,  0,  0,      0, 1'b0);
		add_step(BTN_INC,   AL_SEC,                 0,        0,  0,  AL_SEC, 0, 1'b0);
		add_step(BTN_ALARM, 1,                      0,        0,  0,  AL_SEC, 0, 1'b0);
		add_step(BTN_NONE,  0,                      AL_WAIT,  0,  0,  AL_SEC, 0, 1'b1);
		add_step(BTN_ALARM, 1,                      0,        0,  0,  AL_SEC, 0, 1'b0);
		table_ready = 1'b1;

		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (i = 0; i < n_steps; i++) begin
			run_step(i);
		end

		$display("%0d of %0d steps ok, %0d errors", steps_ok, n_steps, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// watchdog, twice the table's waits and press times
	initial begin
		longint limit_ns;
		int i;
		wait (table_ready);
		limit_ns = 4;	// reset
		for (i = 0; i < n_steps; i++) begin
			limit_ns += st_wait[i] + st_count[i] * 2 * HOLD_CYC;
		end
		limit_ns = 2 * limit_ns * CLK_NS;
		#(limit_ns);
		$display("watchdog: run still busy after %0d ns", limit_ns);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
